// File: design/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

	// one word, also the address width
	parameter int XLEN = 32;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		opcLui    = 7'b0110111,
		opcAuipc  = 7'b0010111,
		opcJal    = 7'b1101111,
		opcJalr   = 7'b1100111,
		opcBranch = 7'b1100011,
		opcLoad   = 7'b0000011,
		opcStore  = 7'b0100011,
		opcOpImm  = 7'b0010011,
		opcOp     = 7'b0110011,
		opcSystem = 7'b1110011
	} opcodeE;

	// immediate formats
	typedef enum logic [2:0] {
		immI,
		immS,
		immB,
		immU,
		immJ
	} immTypeE;

	// the only system instruction accepted
	parameter logic [XLEN-1:0] EBREAK_INST = 32'h0010_0073;

	// funct7 of sub and sra
	parameter logic [6:0] FUNCT7_ALT = 7'b0100000;

endpackage

`default_nettype wire

// File: design/rvCtrlPkg.sv
`default_nettype none

package rvCtrlPkg;

	// alu operations, passB is for lui
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluPassB
	} aluOpE;

	// write-back source
	typedef enum logic [1:0] {
		wbSelAlu,
		wbSelMem,
		wbSelPcPlus4,
		wbSelPcImm
	} wbSelE;

	// next pc choice
	typedef enum logic [1:0] {
		pcSelPlus4,
		pcSelBranch,
		pcSelJalr,
		pcSelHold
	} pcSelE;

	// access size, matches funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		memByte = 2'b00,
		memHalf = 2'b01,
		memWord = 2'b10
	} memSizeE;

endpackage

`default_nettype wire

// File: design/ctrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;

	rvCtrlPkg::aluOpE   aluOp;
	logic               aluSrcImm;
	rvIsaPkg::immTypeE  immType;
	logic               regWrite;
	rvCtrlPkg::wbSelE   wbSel;
	logic               branch;
	logic               jump;
	logic               memRead;
	logic               memWrite;
	rvCtrlPkg::memSizeE memSize;
	logic               memSigned;

	modport decoder (
		output aluOp, aluSrcImm, immType, regWrite, wbSel, branch, jump,
		output memRead, memWrite, memSize, memSigned
	);

	modport datapath (
		input aluOp, aluSrcImm, immType, regWrite, wbSel, branch, jump,
		input memRead, memWrite, memSize, memSigned
	);

endinterface

`default_nettype wire

// File: design/instDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instDecoder (
	input  wire logic                      rst,
	input  wire logic [rvIsaPkg::XLEN-1:0] inst,
	ctrlIf.decoder                         ctrl,
	output logic                           invalid,
	output logic                           halt
);

	rvIsaPkg::opcodeE opcode;
	logic [2:0]       funct3;
	logic [6:0]       funct7;
	logic             valid;
	logic             isEbreak;

	assign opcode = rvIsaPkg::opcodeE'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	// funct3 to alu op, alt selects sub / sra
	function automatic rvCtrlPkg::aluOpE aluOpFor(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? rvCtrlPkg::aluSub : rvCtrlPkg::aluAdd;
			3'b001:  return rvCtrlPkg::aluSll;
			3'b010:  return rvCtrlPkg::aluSlt;
			3'b011:  return rvCtrlPkg::aluSltu;
			3'b100:  return rvCtrlPkg::aluXor;
			3'b101:  return alt ? rvCtrlPkg::aluSra : rvCtrlPkg::aluSrl;
			3'b110:  return rvCtrlPkg::aluOr;
			default: return rvCtrlPkg::aluAnd;
		endcase
	endfunction

	always_comb begin
		ctrl.aluOp     = rvCtrlPkg::aluAdd;
		ctrl.aluSrcImm = 1'b0;
		ctrl.immType   = rvIsaPkg::immI;
		ctrl.regWrite  = 1'b0;
		ctrl.wbSel     = rvCtrlPkg::wbSelAlu;
		ctrl.branch    = 1'b0;
		ctrl.jump      = 1'b0;
		ctrl.memRead   = 1'b0;
		ctrl.memWrite  = 1'b0;
		ctrl.memSize   = rvCtrlPkg::memWord;
		ctrl.memSigned = 1'b0;
		valid          = 1'b0;
		isEbreak       = 1'b0;

		case (opcode)
			rvIsaPkg::opcLui: begin
				valid          = 1'b1;
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.immType   = rvIsaPkg::immU;
				ctrl.aluOp     = rvCtrlPkg::aluPassB;
			end
			rvIsaPkg::opcAuipc: begin
				valid         = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.immType  = rvIsaPkg::immU;
				ctrl.wbSel    = rvCtrlPkg::wbSelPcImm;
			end
			rvIsaPkg::opcJal: begin
				valid         = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.jump     = 1'b1;
				ctrl.immType  = rvIsaPkg::immJ;
				ctrl.wbSel    = rvCtrlPkg::wbSelPcPlus4;
			end
			rvIsaPkg::opcJalr: begin
				valid          = (funct3 == 3'b000);
				ctrl.regWrite  = valid;
				ctrl.jump      = valid;
				ctrl.aluSrcImm = 1'b1;
				ctrl.wbSel     = rvCtrlPkg::wbSelPcPlus4;
			end
			rvIsaPkg::opcBranch: begin
				// beq only, compared through sub
				valid        = (funct3 == 3'b000);
				ctrl.branch  = valid;
				ctrl.immType = rvIsaPkg::immB;
				ctrl.aluOp   = rvCtrlPkg::aluSub;
			end
			rvIsaPkg::opcLoad: begin
				valid          = (funct3 != 3'b011) && (funct3 != 3'b110) && (funct3 != 3'b111);
				ctrl.regWrite  = valid;
				ctrl.memRead   = valid;
				ctrl.aluSrcImm = 1'b1;
				ctrl.wbSel     = rvCtrlPkg::wbSelMem;
				ctrl.memSize   = rvCtrlPkg::memSizeE'(funct3[1:0]);
				ctrl.memSigned = ~funct3[2];
			end
			rvIsaPkg::opcStore: begin
				valid          = (funct3[2] == 1'b0) && (funct3[1:0] != 2'b11);
				ctrl.memWrite  = valid;
				ctrl.aluSrcImm = 1'b1;
				ctrl.immType   = rvIsaPkg::immS;
				ctrl.memSize   = rvCtrlPkg::memSizeE'(funct3[1:0]);
			end
			rvIsaPkg::opcOpImm: begin
				// shift immediates are outside the subset
				valid          = (funct3 != 3'b001) && (funct3 != 3'b101);
				ctrl.regWrite  = valid;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp     = aluOpFor(funct3, 1'b0);
			end
			rvIsaPkg::opcOp: begin
				valid = (funct7 == 7'b0) ||
					((funct7 == rvIsaPkg::FUNCT7_ALT) && (funct3 == 3'b000 || funct3 == 3'b101));
				ctrl.regWrite = valid;
				ctrl.aluOp    = aluOpFor(funct3, funct7[5]);
			end
			rvIsaPkg::opcSystem: begin
				isEbreak = (inst == rvIsaPkg::EBREAK_INST);
				valid    = isEbreak;
			end
			default: begin
				valid = 1'b0;
			end
		endcase

		// nothing may write or redirect while in reset
		if (rst) begin
			ctrl.regWrite = 1'b0;
			ctrl.memRead  = 1'b0;
			ctrl.memWrite = 1'b0;
			ctrl.branch   = 1'b0;
			ctrl.jump     = 1'b0;
		end
	end

	assign invalid = ~valid & ~rst;
	assign halt    = isEbreak & ~rst;

endmodule

`default_nettype wire

// File: design/immGen.sv
`timescale 1ns/1ps
`default_nettype none

module immGen (
	input  wire logic [rvIsaPkg::XLEN-1:0] inst,
	ctrlIf.datapath                        ctrl,
	output logic      [rvIsaPkg::XLEN-1:0] imm
);

	always_comb begin
		case (ctrl.immType)
			rvIsaPkg::immI: imm = {{20{inst[31]}}, inst[31:20]};
			rvIsaPkg::immS: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			// bit 0 is implied zero for B and J
			rvIsaPkg::immB: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
				inst[11:8], 1'b0};
			rvIsaPkg::immU: imm = {inst[31:12], 12'b0};
			rvIsaPkg::immJ: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
				inst[30:21], 1'b0};
			default:        imm = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire logic [4:0]                rs1,
	input  wire logic [4:0]                rs2,
	input  wire logic [4:0]                rd,
	input  wire logic [rvIsaPkg::XLEN-1:0] writeData,
	ctrlIf.datapath                        ctrl,
	output logic      [rvIsaPkg::XLEN-1:0] rdata1,
	output logic      [rvIsaPkg::XLEN-1:0] rdata2
);

	logic [rvIsaPkg::XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.regWrite && rd != 5'd0) begin
			regs[rd] <= writeData;
		end
	end

	// x0 reads zero whatever is stored
	assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire logic [rvIsaPkg::XLEN-1:0] srcA,
	input  wire logic [rvIsaPkg::XLEN-1:0] srcB,
	ctrlIf.datapath                        ctrl,
	output logic      [rvIsaPkg::XLEN-1:0] result,
	output logic                           zero
);

	logic [4:0] shamt;
	logic       lessSigned;
	logic       lessUnsigned;

	assign shamt        = srcB[4:0];
	assign lessSigned   = $signed(srcA) < $signed(srcB);
	assign lessUnsigned = srcA < srcB;

	always_comb begin
		case (ctrl.aluOp)
			rvCtrlPkg::aluAdd:   result = srcA + srcB;
			rvCtrlPkg::aluSub:   result = srcA - srcB;
			rvCtrlPkg::aluSll:   result = srcA << shamt;
			rvCtrlPkg::aluSlt:   result = {{(rvIsaPkg::XLEN-1){1'b0}}, lessSigned};
			rvCtrlPkg::aluSltu:  result = {{(rvIsaPkg::XLEN-1){1'b0}}, lessUnsigned};
			rvCtrlPkg::aluXor:   result = srcA ^ srcB;
			rvCtrlPkg::aluSrl:   result = srcA >> shamt;
			rvCtrlPkg::aluSra:   result = $unsigned($signed(srcA) >>> shamt);
			rvCtrlPkg::aluOr:    result = srcA | srcB;
			rvCtrlPkg::aluAnd:   result = srcA & srcB;
			rvCtrlPkg::aluPassB: result = srcB;
			default:             result = '0;
		endcase
	end

	// beq tests this after sub
	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: design/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module pcUnit #(
	parameter logic [rvIsaPkg::XLEN-1:0] RESET_PC = 32'h8000_0000
) (
	input  wire logic                      clk,
	input  wire logic                      rst,
	ctrlIf.datapath                        ctrl,
	input  wire logic                      zero,
	input  wire logic [rvIsaPkg::XLEN-1:0] imm,
	input  wire logic [rvIsaPkg::XLEN-1:0] aluResult,
	input  wire logic                      halt,
	output logic      [rvIsaPkg::XLEN-1:0] pc,
	output logic      [rvIsaPkg::XLEN-1:0] pcPlus4,
	output logic      [rvIsaPkg::XLEN-1:0] pcImm
);

	rvCtrlPkg::pcSelE          pcSel;
	logic [rvIsaPkg::XLEN-1:0] nextPc;

	assign pcPlus4 = pc + 32'd4;
	assign pcImm   = pc + imm;

	// jal carries a J immediate, jalr an I immediate
	always_comb begin
		if (halt) begin
			pcSel = rvCtrlPkg::pcSelHold;
		end else if (ctrl.jump && ctrl.immType == rvIsaPkg::immJ) begin
			pcSel = rvCtrlPkg::pcSelBranch;
		end else if (ctrl.jump) begin
			pcSel = rvCtrlPkg::pcSelJalr;
		end else if (ctrl.branch && zero) begin
			pcSel = rvCtrlPkg::pcSelBranch;
		end else begin
			pcSel = rvCtrlPkg::pcSelPlus4;
		end
	end

	always_comb begin
		case (pcSel)
			rvCtrlPkg::pcSelBranch: nextPc = pcImm;
			rvCtrlPkg::pcSelJalr:   nextPc = {aluResult[rvIsaPkg::XLEN-1:1], 1'b0};
			rvCtrlPkg::pcSelHold:   nextPc = pc;
			default:                nextPc = pcPlus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

// File: design/loadStoreUnit.sv
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit (
	ctrlIf.datapath                        ctrl,
	input  wire logic [rvIsaPkg::XLEN-1:0] aluResult,
	input  wire logic [rvIsaPkg::XLEN-1:0] rs2Data,
	input  wire logic [rvIsaPkg::XLEN-1:0] readData,
	output logic      [rvIsaPkg::XLEN-1:0] dataAddr,
	output logic      [rvIsaPkg::XLEN-1:0] writeData,
	output logic      [3:0]                writeMask,
	output logic                           memRead,
	output logic                           memWrite,
	output logic      [rvIsaPkg::XLEN-1:0] loadData
);

	assign dataAddr  = aluResult;
	assign writeData = rs2Data;
	assign memRead   = ctrl.memRead;
	assign memWrite  = ctrl.memWrite;

	// memory returns bytes from the address upward, so low bits hold the data
	always_comb begin
		case (ctrl.memSize)
			rvCtrlPkg::memByte: begin
				writeMask = 4'b0001;
				loadData  = {{24{ctrl.memSigned & readData[7]}}, readData[7:0]};
			end
			rvCtrlPkg::memHalf: begin
				writeMask = 4'b0011;
				loadData  = {{16{ctrl.memSigned & readData[15]}}, readData[15:0]};
			end
			default: begin
				writeMask = 4'b1111;
				loadData  = readData;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: design/rvCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore #(
	parameter logic [rvIsaPkg::XLEN-1:0] RESET_PC = 32'h8000_0000
) (
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire logic [rvIsaPkg::XLEN-1:0] inst,
	output logic      [rvIsaPkg::XLEN-1:0] pc,
	output logic      [rvIsaPkg::XLEN-1:0] dataAddr,
	output logic      [rvIsaPkg::XLEN-1:0] writeData,
	output logic      [3:0]                writeMask,
	output logic                           memRead,
	output logic                           memWrite,
	input  wire logic [rvIsaPkg::XLEN-1:0] readData,
	output logic                           invalid,
	output logic                           halt
);

	logic [rvIsaPkg::XLEN-1:0] imm;
	logic [rvIsaPkg::XLEN-1:0] rdata1;
	logic [rvIsaPkg::XLEN-1:0] rdata2;
	logic [rvIsaPkg::XLEN-1:0] srcB;
	logic [rvIsaPkg::XLEN-1:0] aluResult;
	logic                      zero;
	logic [rvIsaPkg::XLEN-1:0] loadData;
	logic [rvIsaPkg::XLEN-1:0] pcPlus4;
	logic [rvIsaPkg::XLEN-1:0] pcImm;
	logic [rvIsaPkg::XLEN-1:0] wbData;

	ctrlIf ctrl ();

	instDecoder uDecoder (
		.rst     (rst),
		.inst    (inst),
		.ctrl    (ctrl.decoder),
		.invalid (invalid),
		.halt    (halt)
	);

	immGen uImmGen (
		.inst (inst),
		.ctrl (ctrl.datapath),
		.imm  (imm)
	);

	regFile uRegFile (
		.clk       (clk),
		.rst       (rst),
		.rs1       (inst[19:15]),
		.rs2       (inst[24:20]),
		.rd        (inst[11:7]),
		.writeData (wbData),
		.ctrl      (ctrl.datapath),
		.rdata1    (rdata1),
		.rdata2    (rdata2)
	);

	// second operand is rs2 or the immediate
	assign srcB = ctrl.aluSrcImm ? imm : rdata2;

	alu uAlu (
		.srcA   (rdata1),
		.srcB   (srcB),
		.ctrl   (ctrl.datapath),
		.result (aluResult),
		.zero   (zero)
	);

	pcUnit #(
		.RESET_PC (RESET_PC)
	) uPcUnit (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (ctrl.datapath),
		.zero      (zero),
		.imm       (imm),
		.aluResult (aluResult),
		.halt      (halt),
		.pc        (pc),
		.pcPlus4   (pcPlus4),
		.pcImm     (pcImm)
	);

	loadStoreUnit uLsu (
		.ctrl      (ctrl.datapath),
		.aluResult (aluResult),
		.rs2Data   (rdata2),
		.readData  (readData),
		.dataAddr  (dataAddr),
		.writeData (writeData),
		.writeMask (writeMask),
		.memRead   (memRead),
		.memWrite  (memWrite),
		.loadData  (loadData)
	);

	// write-back source
	always_comb begin
		case (ctrl.wbSel)
			rvCtrlPkg::wbSelMem:     wbData = loadData;
			rvCtrlPkg::wbSelPcPlus4: wbData = pcPlus4;
			rvCtrlPkg::wbSelPcImm:   wbData = pcImm;
			default:                 wbData = aluResult;
		endcase
	end

endmodule

`default_nettype wire

// File: tests/rvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;

	localparam logic [31:0] RESET_PC = 32'h8000_0000;
	localparam int PERIOD = 4;
	localparam int RESET_CYCLES = 8;
	localparam int ALU_COUNT = 40;
	localparam int TOTAL_INSTS = 2 * ALU_COUNT + 200;

	logic clk;
	logic rst;
	logic [31:0] inst;
	logic [31:0] pc;
	logic [31:0] dataAddr;
	logic [31:0] writeData;
	logic [3:0] writeMask;
	logic memRead;
	logic memWrite;
	logic [31:0] readData;
	logic invalid;
	logic halt;

	logic [31:0] prog [logic [31:0]];
	logic [7:0] dmem [1024];
	logic [31:0] mreg [32];
	logic [31:0] mpc;
	logic [31:0] lcgState;
	int errors;
	int testErrors;
	int testsRun;
	int testsFailed;

	rvCore #(.RESET_PC(RESET_PC)) rvCore_inst (
		.clk(clk), .rst(rst), .inst(inst), .pc(pc), .dataAddr(dataAddr),
		.writeData(writeData), .writeMask(writeMask), .memRead(memRead),
		.memWrite(memWrite), .readData(readData), .invalid(invalid), .halt(halt)
	);

	always #(PERIOD / 2) clk = ~clk;

	// memory answers within the cycle with bytes from the address upward
	assign readData = {dmem[dataAddr[9:0] + 10'd3], dmem[dataAddr[9:0] + 10'd2],
		dmem[dataAddr[9:0] + 10'd1], dmem[dataAddr[9:0]]};

	function automatic logic [7:0] fillByte(input logic [9:0] a);
		return a[7:0] ^ {a[9:8], 6'h2b};
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 1024; i++) begin
				dmem[i] <= fillByte(10'(i));
			end
		end else if (memWrite) begin
			for (int i = 0; i < 4; i++) begin
				if (writeMask[i]) begin
					dmem[dataAddr[9:0] + 10'(i)] <= writeData[8*i +: 8];
				end
			end
		end
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// instruction encoders
	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rvIsaPkg::opcOp};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rvIsaPkg::opcStore};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], rvIsaPkg::opcBranch};
	endfunction

	function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvIsaPkg::opcJal};
	endfunction

	// reference ALU from the RV32I definitions
	function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic check(input logic ok, input string msg);
		assert (ok) else begin
			$display("FAILED at %0t ns: %s", $time, msg);
			errors++;
		end
	endtask

	task automatic endTest(input string name);
		$display("test %s: %0d errors", name, errors - testErrors);
		testsRun++;
		if (errors != testErrors) begin
			testsFailed++;
		end
		testErrors = errors;
	endtask

	// runs one instruction on the DUT and on the model and compares
	task automatic exec(input logic [31:0] ins);
		logic [6:0] op;
		logic [2:0] f3;
		logic [4:0] rd;
		logic [31:0] a, b, iI, iS, iB, iU, iJ, addr, word, npc, val;
		logic wb, eInv, eHalt, eRd, eWr;
		logic [3:0] mask;
		prog[mpc] = ins;
		@(negedge clk);
		// the first instruction also ends reset
		rst = 1'b0;
		inst = prog.exists(pc) ? prog[pc] : 32'h0;
		#1;
		op = ins[6:0];
		f3 = ins[14:12];
		rd = ins[11:7];
		a = mreg[ins[19:15]];
		b = mreg[ins[24:20]];
		iI = {{20{ins[31]}}, ins[31:20]};
		iS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		iB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		iU = {ins[31:12], 12'b0};
		iJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		{wb, eInv, eHalt, eRd, eWr} = '0;
		npc = mpc + 32'd4;
		val = '0;
		addr = '0;
		mask = '0;
		case (op)
			rvIsaPkg::opcLui: {wb, val} = {1'b1, iU};
			rvIsaPkg::opcAuipc: {wb, val} = {1'b1, mpc + iU};
			rvIsaPkg::opcJal: begin
				{wb, val} = {1'b1, mpc + 32'd4};
				npc = mpc + iJ;
			end
			rvIsaPkg::opcJalr: begin
				eInv = (f3 != 3'd0);
				{wb, val} = {~eInv, mpc + 32'd4};
				if (!eInv) npc = (a + iI) & ~32'd1;
			end
			rvIsaPkg::opcBranch: begin
				eInv = (f3 != 3'd0);
				if (!eInv && a == b) npc = mpc + iB;
			end
			rvIsaPkg::opcLoad: begin
				eInv = !(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
				addr = a + iI;
				word = {dmem[addr[9:0] + 10'd3], dmem[addr[9:0] + 10'd2],
					dmem[addr[9:0] + 10'd1], dmem[addr[9:0]]};
				case (f3)
					3'd0: val = {{24{word[7]}}, word[7:0]};
					3'd1: val = {{16{word[15]}}, word[15:0]};
					3'd4: val = {24'b0, word[7:0]};
					3'd5: val = {16'b0, word[15:0]};
					default: val = word;
				endcase
				{wb, eRd} = {~eInv, ~eInv};
			end
			rvIsaPkg::opcStore: begin
				eInv = (f3 > 3'd2);
				eWr = ~eInv;
				addr = a + iS;
				mask = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
			end
			rvIsaPkg::opcOpImm: begin
				eInv = (f3 == 3'd1 || f3 == 3'd5);
				{wb, val} = {~eInv, aluRef(f3, 1'b0, a, iI)};
			end
			rvIsaPkg::opcOp: begin
				eInv = !(ins[31:25] == 7'd0 ||
					(ins[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
				{wb, val} = {~eInv, aluRef(f3, ins[30], a, b)};
			end
			rvIsaPkg::opcSystem: begin
				eHalt = (ins == rvIsaPkg::EBREAK_INST);
				eInv = ~eHalt;
				if (eHalt) npc = mpc;
			end
			default: eInv = 1'b1;
		endcase
		check(pc == mpc, $sformatf("pc %h, expected %h", pc, mpc));
		check(invalid == eInv, $sformatf("invalid %b for %h", invalid, ins));
		check(halt == eHalt, $sformatf("halt %b for %h", halt, ins));
		check(memRead == eRd, $sformatf("memRead %b for %h", memRead, ins));
		check(memWrite == eWr, $sformatf("memWrite %b for %h", memWrite, ins));
		if (eWr) begin
			check(dataAddr == addr, $sformatf("store addr %h, expected %h", dataAddr, addr));
			check(writeMask == mask, $sformatf("mask %b, expected %b", writeMask, mask));
			check(writeData == b, $sformatf("writeData %h, expected %h", writeData, b));
		end
		if (eRd) begin
			check(dataAddr == addr, $sformatf("load addr %h, expected %h", dataAddr, addr));
		end
		if (wb && !eInv && rd != 5'd0) begin
			mreg[rd] = val;
		end
		mpc = npc;
	endtask

	task automatic storeReg(input logic [4:0] r);
		exec(encS(12'h100, r, 5'd0, 3'd2));
	endtask

	initial begin
		#(PERIOD * (TOTAL_INSTS + RESET_CYCLES) + 100);
		$display("timeout: the run did not finish in time");
		$display("Something failed");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [2:0] f3;
		logic [4:0] rd;
		clk = 1'b0;
		rst = 1'b1;
		inst = 32'h0;
		lcgState = 32'h4c44_c4eb;
		mpc = RESET_PC;
		{errors, testErrors, testsRun, testsFailed} = '0;
		for (int i = 0; i < 32; i++) begin
			mreg[i] = '0;
		end

		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clk);
			// words that would act if reset did not gate them
			case (i % 4)
				0: inst = encS(12'h100, 5'd1, 5'd0, 3'd2);
				1: inst = encI(12'h100, 5'd0, 3'd2, 5'd1, rvIsaPkg::opcLoad);
				2: inst = rvIsaPkg::EBREAK_INST;
				default: inst = 32'h0;
			endcase
			#1;
			check(pc == RESET_PC, "pc not at reset address");
			check(!memRead && !memWrite, "memory strobe active in reset");
			check(!invalid && !halt, "invalid or halt active in reset");
		end
		endTest("reset");

		// random contents for x1 to x12
		for (int i = 1; i <= 12; i++) begin
			exec(encU(20'(nextRand() >> 12), 5'(i), rvIsaPkg::opcLui));
			exec(encI(12'(nextRand()), 5'(i), 3'd0, 5'(i), rvIsaPkg::opcOpImm));
		end
		// kind and funct3 step through every op while operands stay random
		for (int k = 0; k < ALU_COUNT; k++) begin
			r = nextRand();
			f3 = 3'(k / 3);
			rd = 5'(32'd1 + (nextRand() >> 8) % 32'd12);
			case (k % 3)
				0: exec(encR({1'b0, (k / 3) >= 8 && (f3 == 3'd0 || f3 == 3'd5), 5'd0},
					5'(32'd1 + 32'(r[11:8]) % 32'd12), 5'(32'd1 + 32'(r[15:12]) % 32'd12),
					f3, rd));
				1: begin
					if (f3 == 3'd1 || f3 == 3'd5) begin
						f3 = f3 - 3'd1;
					end
					exec(encI(r[27:16], 5'(32'd1 + 32'(r[11:8]) % 32'd12), f3, rd,
						rvIsaPkg::opcOpImm));
				end
				default: exec(encU(r[31:12], rd,
					f3[0] ? rvIsaPkg::opcLui : rvIsaPkg::opcAuipc));
			endcase
			storeReg(rd);
		end
		endTest("alu");

		exec(encU(20'(nextRand() >> 12), 5'd6, rvIsaPkg::opcLui));
		exec(encI(12'(nextRand()), 5'd6, 3'd0, 5'd6, rvIsaPkg::opcOpImm));
		for (int pass = 0; pass < 2; pass++) begin
			// inverting x6 gives the sign bits both values
			if (pass == 1) begin
				exec(encI(12'hfff, 5'd6, 3'd4, 5'd6, rvIsaPkg::opcOpImm));
			end
			for (int sz = 0; sz < 3; sz++) begin
				exec(encS(12'(32'h200 + sz * 16), 5'd6, 5'd0, 3'(sz)));
				for (int f = 0; f < 6; f++) begin
					if (f != 3) begin
						exec(encI(12'(32'h200 + sz * 16), 5'd0, 3'(f), 5'd7,
							rvIsaPkg::opcLoad));
						exec(encS(12'h300, 5'd7, 5'd0, 3'd2));
					end
				end
			end
		end
		endTest("load/store");

		exec(encU(20'(nextRand() >> 12), 5'd1, rvIsaPkg::opcLui));
		exec(encI(12'd1, 5'd1, 3'd0, 5'd2, rvIsaPkg::opcOpImm));
		exec(encB(13'd12, 5'd1, 5'd1));
		exec(encB(13'd8, 5'd2, 5'd1));
		exec(encJ(21'd20, 5'd3));
		// odd offset whose bit 0 the target drops
		exec(encI(12'd37, 5'd3, 3'd0, 5'd4, rvIsaPkg::opcJalr));
		storeReg(5'd3);
		storeReg(5'd4);
		endTest("control flow");

		exec({20'(nextRand() >> 12), 5'd9, 7'b0001111});
		exec(encR(7'b0000001, 5'd1, 5'd2, 3'd0, 5'd5));
		exec(encI(12'd3, 5'd1, 3'd1, 5'd6, rvIsaPkg::opcOpImm));
		exec(encI(12'd0, 5'd0, 3'd3, 5'd7, rvIsaPkg::opcLoad));
		exec(encS(12'h100, 5'd1, 5'd0, 3'd3));
		// bne on equal operands so a stray branch would jump
		exec({7'd0, 5'd1, 5'd1, 3'd1, 5'd8, rvIsaPkg::opcBranch});
		exec(32'h0000_0073);
		for (int i = 1; i <= 12; i++) begin
			storeReg(5'(i));
		end
		endTest("invalid");

		repeat (4) begin
			exec(rvIsaPkg::EBREAK_INST);
		end
		endTest("ebreak");

		$display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
design/rvIsaPkg.sv
design/rvCtrlPkg.sv
design/ctrlIf.sv
design/instDecoder.sv
design/immGen.sv
design/regFile.sv
design/alu.sv
design/pcUnit.sv
design/loadStoreUnit.sv
design/rvCore.sv
tests/rvCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= rvCoreTb
FILELIST  ?= src.f
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
